/* common/bus_pkg.sv */
`default_nettype none

package bus_pkg;

	//////////////////////////////////////////////////
	// Address map
	//////////////////////////////////////////////////

	localparam int ADDR_W    = 12;
	localparam int RAM_WORDS = 64;
	localparam int RAM_IDX_W = $clog2(RAM_WORDS);

	// Byte addresses, word aligned
	localparam logic [ADDR_W-1:0] RAM_LIMIT   = ADDR_W'(RAM_WORDS * 4);
	localparam logic [ADDR_W-1:0] ADDR_TX     = 12'h100;
	localparam logic [ADDR_W-1:0] ADDR_RX     = 12'h104;
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 12'h108;
	localparam logic [ADDR_W-1:0] ADDR_CYCLES = 12'h10C;
	localparam logic [ADDR_W-1:0] ADDR_HALT   = 12'h110;

	localparam logic [31:0] UNMAPPED_DATA = 32'hBAD0_ADD5;

	// Status word bits
	localparam int STATUS_TX_FULL  = 0;
	localparam int STATUS_RX_EMPTY = 1;

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		OP_READ  = 2'd0,
		OP_WRITE = 2'd1
	} bus_op_e;

	typedef enum logic [2:0] {
		REGION_RAM    = 3'd0,
		REGION_TX     = 3'd1,
		REGION_RX     = 3'd2,
		REGION_STATUS = 3'd3,
		REGION_CYCLES = 3'd4,
		REGION_HALT   = 3'd5,
		REGION_NONE   = 3'd6
	} region_e;

	typedef struct packed {
		logic              valid;
		bus_op_e           op;
		logic [ADDR_W-1:0] addr;
		logic [31:0]       wdata;
		logic [3:0]        be;
	} bus_req_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] rdata;
	} bus_rsp_t;

	// Decoded request held between decode and execute
	typedef struct packed {
		logic                 valid;
		bus_op_e              op;
		region_e              region;
		logic [RAM_IDX_W-1:0] ram_idx;
		logic [31:0]          wdata;
		logic [3:0]           be;
	} stage_t;

	// Execute to result, raw read data plus where it came from
	typedef struct packed {
		bus_rsp_t rsp;
		region_e  region;
	} exec_t;

endpackage

`default_nettype wire

/* common/serial_pkg.sv */
`default_nettype none

package serial_pkg;

	// 8N1 framing
	localparam int BIT_CYCLES = 4;
	localparam int FRAME_BITS = 10;

	localparam int TX_DEPTH = 4;
	localparam int RX_DEPTH = 4;

	localparam int BIT_CNT_W   = $clog2(BIT_CYCLES);
	localparam int FRAME_CNT_W = $clog2(FRAME_BITS);
	localparam int TX_PTR_W    = $clog2(TX_DEPTH);
	localparam int RX_PTR_W    = $clog2(RX_DEPTH);

	// Counter end values
	localparam logic [BIT_CNT_W-1:0]   BIT_LAST   = BIT_CNT_W'(BIT_CYCLES - 1);
	localparam logic [BIT_CNT_W-1:0]   BIT_HALF   = BIT_CNT_W'(BIT_CYCLES / 2);
	localparam logic [FRAME_CNT_W-1:0] FRAME_LAST = FRAME_CNT_W'(FRAME_BITS - 1);
	localparam logic [RX_PTR_W:0]      RX_FULL    = (RX_PTR_W + 1)'(RX_DEPTH);

	typedef logic [2:0] credit_t;

	// One credit per free transmit FIFO slot
	localparam credit_t CREDIT_INIT = credit_t'(TX_DEPTH);

endpackage

`default_nettype wire

/* design/mmu_decode.sv */
`default_nettype none

module mmu_decode (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire bus_pkg::bus_req_t req,
	input  wire logic              stall,
	output bus_pkg::stage_t        stage
);

	bus_pkg::region_e region;

	// Address to region
	always_comb begin
		if (req.addr < bus_pkg::RAM_LIMIT) begin
			region = bus_pkg::REGION_RAM;
		end else begin
			case (req.addr)
				bus_pkg::ADDR_TX:     region = bus_pkg::REGION_TX;
				bus_pkg::ADDR_RX:     region = bus_pkg::REGION_RX;
				bus_pkg::ADDR_STATUS: region = bus_pkg::REGION_STATUS;
				bus_pkg::ADDR_CYCLES: region = bus_pkg::REGION_CYCLES;
				bus_pkg::ADDR_HALT:   region = bus_pkg::REGION_HALT;
				default:              region = bus_pkg::REGION_NONE;
			endcase
		end
	end

	// Held while execute is stalled on a transmit write
	always_ff @(posedge clk) begin
		if (!stall) begin
			stage.op      <= req.op;
			stage.region  <= region;
			stage.ram_idx <= req.addr[bus_pkg::RAM_IDX_W+1:2];
			stage.wdata   <= req.wdata;
			stage.be      <= req.be;
		end
		if (rst) begin
			stage.valid <= 1'b0;
		end else if (!stall) begin
			stage.valid <= req.valid;
		end
	end

endmodule

`default_nettype wire

/* design/mmu_execute.sv */
`default_nettype none

module mmu_execute (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire bus_pkg::stage_t  stage,
	input  wire logic [7:0]       rx_byte,
	input  wire logic             rx_empty,
	input  wire logic             credit_return,
	output logic                  stall,
	output logic                  tx_push,
	output logic [7:0]            tx_byte,
	output logic                  rx_pop,
	output bus_pkg::exec_t        result
);

	logic [31:0] ram [bus_pkg::RAM_WORDS];

	serial_pkg::credit_t credits;
	logic [31:0]         cycles;
	logic                halted;

	logic           is_read;
	logic           is_write;
	logic           tx_item;
	logic           ram_write;
	logic           halt_write;
	logic [31:0]    status;
	logic [31:0]    rdata;
	bus_pkg::exec_t result_q;

	//////////////////////////////////////////////////
	// Access decode
	//////////////////////////////////////////////////

	always_comb begin
		is_read    = stage.valid && stage.op == bus_pkg::OP_READ;
		is_write   = stage.valid && stage.op == bus_pkg::OP_WRITE;
		tx_item    = is_write && stage.region == bus_pkg::REGION_TX;
		ram_write  = is_write && stage.region == bus_pkg::REGION_RAM;
		halt_write = is_write && stage.region == bus_pkg::REGION_HALT;

		// No credit left means the transmit FIFO is full
		stall   = tx_item && credits == '0;
		tx_push = tx_item && credits != '0;
		tx_byte = stage.wdata[7:0];
		rx_pop  = is_read && stage.region == bus_pkg::REGION_RX && !rx_empty;
	end

	always_comb begin
		status = '0;
		status[bus_pkg::STATUS_TX_FULL]  = credits == '0;
		status[bus_pkg::STATUS_RX_EMPTY] = rx_empty;

		case (stage.region)
			bus_pkg::REGION_RAM:    rdata = ram[stage.ram_idx];
			bus_pkg::REGION_RX:     rdata = rx_empty ? '0 : {24'd0, rx_byte};
			bus_pkg::REGION_STATUS: rdata = status;
			bus_pkg::REGION_CYCLES: rdata = cycles;
			default:                rdata = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// State
	//////////////////////////////////////////////////

	// Byte-masked RAM write
	always_ff @(posedge clk) begin
		if (ram_write) begin
			for (int b = 0; b < 4; b++) begin
				if (stage.be[b]) begin
					ram[stage.ram_idx][8*b +: 8] <= stage.wdata[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= serial_pkg::CREDIT_INIT;
		end else begin
			case ({credit_return, tx_push})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// Cycle counter stops for good once halt is written
	always_ff @(posedge clk) begin
		if (rst) begin
			cycles <= '0;
			halted <= 1'b0;
		end else begin
			if (halt_write) begin
				halted <= 1'b1;
			end
			if (!halted) begin
				cycles <= cycles + 32'd1;
			end
		end
	end

	// Result register freezes during a stall so an earlier read is not lost
	always_ff @(posedge clk) begin
		if (!stall) begin
			result_q.rsp.rdata <= rdata;
			result_q.region    <= stage.region;
		end
		if (rst) begin
			result_q.rsp.valid <= 1'b0;
		end else if (!stall) begin
			result_q.rsp.valid <= is_read;
		end
	end

	always_comb begin
		result           = result_q;
		result.rsp.valid = result_q.rsp.valid && !stall;
	end

endmodule

`default_nettype wire

/* design/mmu_result.sv */
`default_nettype none

module mmu_result (
	input  wire logic           clk,
	input  wire logic           rst,
	input  wire bus_pkg::exec_t result,
	output bus_pkg::bus_rsp_t   rsp
);

	logic [31:0] rdata;

	// Unmapped reads get a fixed marker pattern
	always_comb begin
		if (result.region == bus_pkg::REGION_NONE) begin
			rdata = bus_pkg::UNMAPPED_DATA;
		end else begin
			rdata = result.rsp.rdata;
		end
	end

	always_ff @(posedge clk) begin
		rsp.rdata <= rdata;
		if (rst) begin
			rsp.valid <= 1'b0;
		end else begin
			// Only reads carry a valid bit from execute
			rsp.valid <= result.rsp.valid;
		end
	end

endmodule

`default_nettype wire

/* serial/spart_tx.sv */
`default_nettype none

module spart_tx (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       tx_push,
	input  wire logic [7:0] tx_byte,
	output logic            credit_return,
	output logic            txd
);

	logic [7:0] fifo [serial_pkg::TX_DEPTH];

	logic [serial_pkg::TX_PTR_W-1:0]    wr_ptr;
	logic [serial_pkg::TX_PTR_W-1:0]    rd_ptr;
	logic [serial_pkg::TX_PTR_W:0]      count;
	logic                               busy;
	logic                               load;
	logic [serial_pkg::FRAME_BITS-1:0]  shift;
	logic [serial_pkg::BIT_CNT_W-1:0]   cyc_cnt;
	logic [serial_pkg::FRAME_CNT_W-1:0] bit_cnt;

	// Shifter idle with a byte waiting, move it out and free its slot
	assign load          = !busy && count != '0;
	assign credit_return = load;
	assign txd           = shift[0];

	//////////////////////////////////////////////////
	// FIFO
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (tx_push) begin
			fifo[wr_ptr] <= tx_byte;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (tx_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (load) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({tx_push, load})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Shifter, LSB first
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			busy    <= 1'b0;
			shift   <= '1;
			cyc_cnt <= '0;
			bit_cnt <= '0;
		end else if (load) begin
			busy    <= 1'b1;
			shift   <= {1'b1, fifo[rd_ptr], 1'b0};
			cyc_cnt <= '0;
			bit_cnt <= '0;
		end else if (busy) begin
			if (cyc_cnt == serial_pkg::BIT_LAST) begin
				cyc_cnt <= '0;
				// Ones fill in behind, so the line idles high
				shift   <= {1'b1, shift[serial_pkg::FRAME_BITS-1:1]};
				if (bit_cnt == serial_pkg::FRAME_LAST) begin
					busy <= 1'b0;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin
				cyc_cnt <= cyc_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* serial/spart_rx.sv */
`default_nettype none

module spart_rx (
	input  wire logic  clk,
	input  wire logic  rst,
	input  wire logic  rxd,
	input  wire logic  rx_pop,
	output logic [7:0] rx_byte,
	output logic       rx_empty
);

	logic [7:0] fifo [serial_pkg::RX_DEPTH];

	logic                               rxd_meta;
	logic                               rxd_sync;
	logic                               rxd_prev;
	logic                               busy;
	logic [serial_pkg::BIT_CNT_W-1:0]   cyc_cnt;
	logic [serial_pkg::FRAME_CNT_W-1:0] bit_cnt;
	logic [7:0]                         data;
	logic                               sample;
	logic                               push;
	logic                               pop;
	logic [serial_pkg::RX_PTR_W-1:0]    wr_ptr;
	logic [serial_pkg::RX_PTR_W-1:0]    rd_ptr;
	logic [serial_pkg::RX_PTR_W:0]      count;

	// Sample point, about mid-bit
	assign sample = busy && cyc_cnt == serial_pkg::BIT_LAST;
	// Good stop bit and room left, otherwise the byte is dropped
	assign push = sample && bit_cnt == serial_pkg::FRAME_LAST && rxd_sync
		&& count != serial_pkg::RX_FULL;
	assign pop      = rx_pop && count != '0;
	assign rx_byte  = fifo[rd_ptr];
	assign rx_empty = count == '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	//////////////////////////////////////////////////
	// Frame sampler
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			busy    <= 1'b0;
			cyc_cnt <= '0;
			bit_cnt <= '0;
		end else if (!busy) begin
			// Falling edge starts a frame, first sample half a bit later
			if (rxd_prev && !rxd_sync) begin
				busy    <= 1'b1;
				cyc_cnt <= serial_pkg::BIT_HALF;
				bit_cnt <= '0;
			end
		end else if (sample) begin
			cyc_cnt <= '0;
			if (bit_cnt == '0 && rxd_sync) begin
				busy <= 1'b0;
			end else if (bit_cnt == serial_pkg::FRAME_LAST) begin
				busy <= 1'b0;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end else begin
			cyc_cnt <= cyc_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (sample && bit_cnt != '0 && bit_cnt != serial_pkg::FRAME_LAST) begin
			data <= {rxd_sync, data[7:1]};
		end
	end

	//////////////////////////////////////////////////
	// FIFO
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (push) begin
			fifo[wr_ptr] <= data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/soc_top.sv */
`default_nettype none

module soc_top (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire bus_pkg::bus_req_t req,
	output bus_pkg::bus_rsp_t      rsp,
	output logic                   stall,
	input  wire logic              rxd,
	output logic                   txd
);

	bus_pkg::stage_t stage;
	bus_pkg::exec_t  result;

	// Serial port side
	logic       tx_push;
	logic [7:0] tx_byte;
	logic       credit_return;
	logic       rx_pop;
	logic [7:0] rx_byte;
	logic       rx_empty;

	//////////////////////////////////////////////////
	// MMU pipeline
	//////////////////////////////////////////////////

	mmu_decode mmu_decode_inst (
		.clk   (clk),
		.rst   (rst),
		.req   (req),
		.stall (stall),
		.stage (stage)
	);

	mmu_execute mmu_execute_inst (
		.clk           (clk),
		.rst           (rst),
		.stage         (stage),
		.rx_byte       (rx_byte),
		.rx_empty      (rx_empty),
		.credit_return (credit_return),
		.stall         (stall),
		.tx_push       (tx_push),
		.tx_byte       (tx_byte),
		.rx_pop        (rx_pop),
		.result        (result)
	);

	mmu_result mmu_result_inst (
		.clk    (clk),
		.rst    (rst),
		.result (result),
		.rsp    (rsp)
	);

	//////////////////////////////////////////////////
	// Serial port
	//////////////////////////////////////////////////

	spart_tx spart_tx_inst (
		.clk           (clk),
		.rst           (rst),
		.tx_push       (tx_push),
		.tx_byte       (tx_byte),
		.credit_return (credit_return),
		.txd           (txd)
	);

	spart_rx spart_rx_inst (
		.clk      (clk),
		.rst      (rst),
		.rxd      (rxd),
		.rx_pop   (rx_pop),
		.rx_byte  (rx_byte),
		.rx_empty (rx_empty)
	);

endmodule

`default_nettype wire

/* testbench/soc_properties.sv */
`default_nettype none

module soc_properties (
	input wire logic clk,
	input wire logic rst,
	input wire logic rsp_valid,
	input wire logic stall,
	input wire logic tx_push,
	input wire logic rx_pop,
	input wire logic credit_return,
	input wire logic tx_busy,
	input wire logic txd
);

	timeunit 1ns;
	timeprecision 100ps;

	// One full frame to free a credit plus a little slack
	localparam int STALL_LIMIT = serial_pkg::FRAME_BITS * serial_pkg::BIT_CYCLES + 4;

	int stall_run;

	always_ff @(posedge clk) begin
		if (rst || !stall) begin
			stall_run <= 0;
		end else begin
			stall_run <= stall_run + 1;
		end
	end

	reset_state: assert property (@(posedge clk)
		rst |=> !rsp_valid && !stall && !tx_push && !rx_pop && !credit_return && txd)
		else $error("Outputs left their reset state during reset");

	no_rsp_in_stall: assert property (@(posedge clk) disable iff (rst)
		!(rsp_valid && stall))
		else $error("Response issued while stalled");

	stall_bounded: assert property (@(posedge clk) disable iff (rst)
		stall_run < STALL_LIMIT)
		else $error("Stall held longer than one frame");

	txd_idle_high: assert property (@(posedge clk) disable iff (rst)
		!tx_busy |-> txd)
		else $error("txd low while the transmitter is idle");

endmodule

bind soc_top soc_properties soc_properties_inst (
	.clk           (clk),
	.rst           (rst),
	.rsp_valid     (rsp.valid),
	.stall         (stall),
	.tx_push       (tx_push),
	.rx_pop        (rx_pop),
	.credit_return (credit_return),
	.tx_busy       (spart_tx_inst.busy),
	.txd           (txd)
);

`default_nettype wire

/* testbench/soc_tb.sv */
`default_nettype none

module soc_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 8;
	localparam int TX_BYTES     = 6;
	// Whole run is well under 1000 cycles, this leaves a wide margin
	localparam int TIMEOUT_CYCLES = 6000;

	// One outstanding read, what it should return and when it was accepted
	typedef struct packed {
		logic        check;
		logic [31:0] data;
		int          cycle;
	} expect_t;

	logic              clk;
	logic              rst;
	bus_pkg::bus_req_t req;
	bus_pkg::bus_rsp_t rsp;
	logic              stall;
	logic              txd;

	logic [31:0] ram_model [bus_pkg::RAM_WORDS];
	logic [31:0] lcg_state;
	int          cycle_count = 0;
	logic        saw_stall;
	expect_t     expect_q [$];
	logic [31:0] seen_q [$];
	logic [7:0]  tx_sent [$];
	logic [7:0]  tx_seen [$];

	// Serial loopback, txd feeds rxd
	soc_top soc_top_inst (
		.clk   (clk),
		.rst   (rst),
		.req   (req),
		.rsp   (rsp),
		.stall (stall),
		.rxd   (txd),
		.txd   (txd)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		assert (cycle_count < TIMEOUT_CYCLES) else begin
			$display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** TEST FAILED ***");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic expect_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Fail %s = 0x%h expected 0x%h", name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			$display("*** TEST FAILED ***");
			$fatal(1, "check failed");
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk);
		#5;
	endtask

	// Called 5 ns after a rising edge, returns 5 ns after the accepting edge
	task automatic issue(input bus_pkg::bus_op_e op, input logic [11:0] addr,
			input logic [31:0] wdata, input logic [3:0] be, input logic check,
			input logic [31:0] data);
		expect_t e;
		req.valid = 1'b1;
		req.op    = op;
		req.addr  = addr;
		req.wdata = wdata;
		req.be    = be;
		@(negedge clk);
		while (stall) begin
			saw_stall = 1'b1;
			@(negedge clk);
		end
		if (op == bus_pkg::OP_READ) begin
			e.check = check;
			e.data  = data;
			e.cycle = cycle_count;
			expect_q.push_back(e);
		end
		@(posedge clk);
		#5;
		req.valid = 1'b0;
	endtask

	task automatic write_ram(input int idx, input logic [31:0] data, input logic [3:0] be);
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				ram_model[idx][8*b +: 8] = data[8*b +: 8];
			end
		end
		issue(bus_pkg::OP_WRITE, 12'(idx * 4), data, be, 1'b0, '0);
	endtask

	task automatic read_check(input logic [11:0] addr, input logic [31:0] exp);
		issue(bus_pkg::OP_READ, addr, '0, '0, 1'b1, exp);
	endtask

	task automatic wait_drain();
		do begin
			@(posedge clk);
		end while (expect_q.size() != 0);
		#5;
	endtask

	task automatic read_value(input logic [11:0] addr, output logic [31:0] data);
		issue(bus_pkg::OP_READ, addr, '0, '0, 1'b0, '0);
		wait_drain();
		data = seen_q[seen_q.size() - 1];
	endtask

	//////////////////////////////////////////////////
	// Monitors
	//////////////////////////////////////////////////

	always @(negedge clk) begin : response_check
		expect_t e;
		if (!rst && rsp.valid) begin
			expect_true(expect_q.size() != 0, "Response arrived with no read outstanding");
			e = expect_q.pop_front();
			seen_q.push_back(rsp.rdata);
			expect_equal("response latency", 32'(cycle_count - e.cycle), 32'd3);
			if (e.check) begin
				expect_equal("rsp.rdata", rsp.rdata, e.data);
			end
		end
	end

	// Decodes 8N1 frames on txd, mid-bit
	initial begin : txd_monitor
		logic [7:0] b;
		forever begin
			@(negedge clk);
			if (!rst && txd === 1'b0) begin
				repeat (serial_pkg::BIT_CYCLES / 2) @(negedge clk);
				for (int i = 0; i < 8; i++) begin
					repeat (serial_pkg::BIT_CYCLES) @(negedge clk);
					b[i] = txd;
				end
				repeat (serial_pkg::BIT_CYCLES) @(negedge clk);
				expect_true(txd === 1'b1, "Stop bit on txd was not high");
				tx_seen.push_back(b);
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin : stimulus
		logic [31:0] value;
		logic [31:0] first;
		int          idx;
		clk       = 1'b0;
		rst       = 1'b1;
		req       = '0;
		lcg_state = 32'd54;
		saw_stall = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#5;
		rst = 1'b0;
		idle(4);

		// Quiet outputs after reset
		expect_equal("stall", 32'(stall), 32'd0);
		expect_equal("rsp.valid", 32'(rsp.valid), 32'd0);
		expect_equal("txd", 32'(txd), 32'd1);
		read_check(bus_pkg::ADDR_STATUS, 32'd1 << bus_pkg::STATUS_RX_EMPTY);

		// RAM, full words first so no byte stays unknown
		for (int i = 0; i < bus_pkg::RAM_WORDS; i++) begin
			write_ram(i, next_random(), 4'hF);
		end
		for (int i = 0; i < 48; i++) begin
			value = next_random();
			idx   = int'(value[21:16]);
			write_ram(idx, next_random(), value[27:24]);
		end
		for (int i = 0; i < bus_pkg::RAM_WORDS; i++) begin
			read_check(12'(i * 4), ram_model[i]);
		end
		wait_drain();

		// Transmit burst, more bytes than credits
		expect_equal("txd", 32'(txd), 32'd1);
		for (int i = 0; i < TX_BYTES; i++) begin
			value = next_random();
			tx_sent.push_back(value[7:0]);
			issue(bus_pkg::OP_WRITE, bus_pkg::ADDR_TX, value, 4'hF, 1'b0, '0);
		end
		// Held behind the stall
		read_check(12'h000, ram_model[0]);
		expect_true(saw_stall, "Stall never rose during the transmit burst");
		while (tx_seen.size() < TX_BYTES) begin
			idle(1);
		end
		idle(20);
		for (int i = 0; i < TX_BYTES; i++) begin
			expect_equal("txd byte", 32'(tx_seen[i]), 32'(tx_sent[i]));
		end

		// Receive FIFO holds the first four, the rest were dropped
		read_check(bus_pkg::ADDR_STATUS, 32'd0);
		for (int i = 0; i < serial_pkg::RX_DEPTH; i++) begin
			read_check(bus_pkg::ADDR_RX, 32'(tx_sent[i]));
		end
		read_check(bus_pkg::ADDR_RX, 32'd0);
		read_check(bus_pkg::ADDR_STATUS, 32'd1 << bus_pkg::STATUS_RX_EMPTY);
		wait_drain();

		// Cycle counter runs, then stops on halt
		read_value(bus_pkg::ADDR_CYCLES, first);
		read_value(bus_pkg::ADDR_CYCLES, value);
		expect_true(value > first, "Cycle counter did not advance");
		issue(bus_pkg::OP_WRITE, bus_pkg::ADDR_HALT, 32'd1, 4'hF, 1'b0, '0);
		idle(2);
		read_value(bus_pkg::ADDR_CYCLES, first);
		idle(5);
		read_value(bus_pkg::ADDR_CYCLES, value);
		expect_equal("halted cycle counter", value, first);

		read_check(12'h200, bus_pkg::UNMAPPED_DATA);
		read_check(12'h114, bus_pkg::UNMAPPED_DATA);
		wait_drain();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
common/bus_pkg.sv
common/serial_pkg.sv
design/mmu_decode.sv
design/mmu_execute.sv
design/mmu_result.sv
serial/spart_tx.sv
serial/spart_rx.sv
design/soc_top.sv
testbench/soc_properties.sv
testbench/soc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module soc_tb -o soc_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/soc_sim +verilator+error+limit+1
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi
exit 0
